// File: sources.f
hw/scb_cfg_pkg.sv
hw/scb_types_pkg.sv
hw/store_intake.sv
hw/commit_line_array.sv
hw/dcache_drain.sv
hw/store_commit_top.sv
verification/store_commit_sva.sv
verification/tb_store_commit.sv

// File: Bender.yml
package:
  name: store_commit_buffer

sources:
  - target: rtl
    files:
      - hw/scb_cfg_pkg.sv
      - hw/scb_types_pkg.sv
      - hw/store_intake.sv
      - hw/commit_line_array.sv
      - hw/dcache_drain.sv
      - hw/store_commit_top.sv
  - target: test
    files:
      - verification/store_commit_sva.sv
      - verification/tb_store_commit.sv

// File: verification/tb_store_commit.sv
`timescale 1ns/1ps

module tb_store_commit;

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    localparam int LINES = 7;                      // Line 6 is only ever loaded, never stored

    logic       clk;
    logic       rst;
    store_req_t store;
    logic       conflict;
    fwd_req_t   fwd;
    fwd_rsp_t   fwd_rsp;
    logic       cache_ready;
    line_wr_t   line_wr;
    cache_rsp_t cache_rsp;

    logic [31:0]                 lfsr;
    logic                        traffic_on;
    logic                        draining;
    store_req_t                  staged;             // Mirror of the intake stage
    logic [3:0]                  shadow_mask [0:LINES-1][0:LINE_BANKS-1];
    logic [31:0]                 shadow_data [0:LINES-1][0:LINE_BANKS-1];
    logic [LINES-1:0]            line_live;
    logic [LINES-1:0]            line_busy;          // Sent to the cache and not yet answered
    logic [SCB_ENTRIES-1:0]      idx_valid;
    int                          idx_line [0:SCB_ENTRIES-1];
    int                          resp_wait [0:SCB_ENTRIES-1];
    logic [SCB_ENTRIES-1:0]      resp_retry;
    logic [3:0]                  exp_fwd_mask;
    logic [31:0]                 exp_fwd_data;
    logic [31:0]                 seen_fwd_data;
    logic [LINE_BANKS-1:0][3:0]  exp_line_mask;
    logic [LINE_BANKS-1:0][31:0] exp_line_data;
    logic [LINE_BANKS-1:0][31:0] seen_line_data;
    int                          staged_line;
    logic                        must_conflict;
    int                          error_count;
    int                          timeout_count;

    store_commit_top uut (
        .clk         (clk),
        .rst         (rst),
        .store       (store),
        .conflict    (conflict),
        .fwd         (fwd),
        .fwd_rsp     (fwd_rsp),
        .cache_ready (cache_ready),
        .line_wr     (line_wr),
        .cache_rsp   (cache_rsp)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] line_base(input int n);
        return 32'h0000_2000 + 32'(n) * 32'h0000_0410;
    endfunction

    function automatic int line_of(input logic [ADDR_W-1:0] addr);
        logic [31:0] base;
        int          n;
        n = LINES - 1;
        for (int i = 0; i < LINES; i++) begin
            base = line_base(i);
            if (addr[ADDR_W-1:LINE_OFS_W] == base[ADDR_W-1:LINE_OFS_W]) begin
                n = i;
            end
        end
        return n;
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] m);
        logic [31:0] r;
        for (int j = 0; j < 4; j++) begin
            r[8*j +: 8] = {8{m[j]}};
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Store source, load port and data cache model
    // --------------------------------------------------
    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] addr;
        logic        sent;
        if (rst) begin
            for (int i = 0; i < SCB_ENTRIES; i++) begin
                resp_wait[i] = 0;
            end
        end else begin
            if (!conflict) begin                   // Current request is taken at this edge
                draw(2, r);
                store.en <= traffic_on && (r != 0);
                draw(3, r);
                addr = line_base(int'(r) % (LINES - 1));
                draw(2, r);
                store.addr <= addr | (r << 2);
                draw(4, r);
                store.mask <= r[3:0];
                draw(32, r);
                store.data <= r;
            end
            draw(1, r);
            fwd.en <= r[0];
            draw(3, r);
            addr = line_base(int'(r) % LINES);
            draw(2, r);
            fwd.addr <= addr | (r << 2);
            draw(2, r);
            cache_ready <= draining || (r != 0);
            cache_rsp <= '0;
            sent = 1'b0;
            for (int i = 0; i < SCB_ENTRIES; i++) begin
                if (resp_wait[i] == 1 && !sent) begin
                    cache_rsp <= '{success: !resp_retry[i], retry: resp_retry[i],
                                   idx: SCB_IDX_W'(i)};
                    resp_wait[i] = 0;
                    sent = 1'b1;
                end else if (resp_wait[i] > 1) begin
                    resp_wait[i] = resp_wait[i] - 1;
                end
            end
            if (line_wr.req) begin
                draw(2, r);
                resp_wait[line_wr.idx] = int'(r) + 1;
                draw(2, r);
                resp_retry[line_wr.idx] <= (r == 0);   // About one answer in four is a retry
            end
        end
    end

    // --------------------------------------------------
    // Shadow of the buffered bytes
    // --------------------------------------------------
    always @(posedge clk) begin
        int fn;
        int rn;
        int sn;
        int bank;
        int k;
        if (rst) begin
            staged.en <= 1'b0;
            line_live <= '0;
            line_busy <= '0;
            idx_valid <= '0;
            exp_fwd_mask <= '0;
            exp_fwd_data <= '0;
            for (int n = 0; n < LINES; n++) begin
                for (int b = 0; b < LINE_BANKS; b++) begin
                    shadow_mask[n][b] <= '0;
                    shadow_data[n][b] <= '0;
                end
            end
        end else begin
            fn = line_of(fwd.addr);
            bank = int'(fwd.addr[LINE_OFS_W-1:2]);
            exp_fwd_mask <= fwd.en ? shadow_mask[fn][bank] : 4'h0;
            exp_fwd_data <= fwd.en ? shadow_data[fn][bank] & byte_mask(shadow_mask[fn][bank])
                                   : 32'h0;
            if (cache_rsp.success || cache_rsp.retry) begin
                rn = idx_line[cache_rsp.idx];
                line_busy[rn] <= 1'b0;
                if (cache_rsp.success) begin
                    idx_valid[cache_rsp.idx] <= 1'b0;
                    line_live[rn] <= 1'b0;
                    for (int b = 0; b < LINE_BANKS; b++) begin
                        shadow_mask[rn][b] <= '0;
                    end
                end
            end
            if (line_wr.req) begin
                line_busy[line_of(line_wr.addr)] <= 1'b1;
            end
            if (!conflict) begin
                if (staged.en) begin
                    sn = line_of(staged.addr);
                    bank = int'(staged.addr[LINE_OFS_W-1:2]);
                    if (line_live[sn]) begin
                        shadow_mask[sn][bank] <= shadow_mask[sn][bank] | staged.mask;
                    end else begin
                        k = 0;
                        for (int i = SCB_ENTRIES - 1; i >= 0; i--) begin
                            if (!idx_valid[i]) k = i;
                        end
                        idx_valid[k] <= 1'b1;
                        idx_line[k] <= sn;
                        line_live[sn] <= 1'b1;
                        for (int b = 0; b < LINE_BANKS; b++) begin
                            shadow_mask[sn][b] <= (b == bank) ? staged.mask : 4'h0;
                        end
                    end
                    for (int j = 0; j < 4; j++) begin
                        if (staged.mask[j]) begin
                            shadow_data[sn][bank][8*j +: 8] <= staged.data[8*j +: 8];
                        end
                    end
                end
                staged <= store;
            end
        end
    end

    always_comb begin
        int n;
        n = line_of(line_wr.addr);
        for (int b = 0; b < LINE_BANKS; b++) begin
            exp_line_mask[b]  = shadow_mask[n][b];
            exp_line_data[b]  = shadow_data[n][b] & byte_mask(shadow_mask[n][b]);
            seen_line_data[b] = line_wr.data[b] & byte_mask(line_wr.mask[b]);
        end
    end

    assign seen_fwd_data = fwd_rsp.data & byte_mask(fwd_rsp.mask);
    assign staged_line   = line_of(staged.addr);
    assign must_conflict = staged.en && (line_busy[staged_line]
                           || (!line_live[staged_line] && $countones(idx_valid) == SCB_ENTRIES));

    // --------------------------------------------------
    // Data checks
    // --------------------------------------------------
    a_fwd_mask: assert property (@(posedge clk) disable iff (rst) fwd_rsp.mask == exp_fwd_mask)
        else begin
            error_count = error_count + 1;
            $display("Fail fwd_rsp.mask expected %h actual %h",
                     $sampled(exp_fwd_mask), $sampled(fwd_rsp.mask));
        end

    a_fwd_data: assert property (@(posedge clk) disable iff (rst) seen_fwd_data == exp_fwd_data)
        else begin
            error_count = error_count + 1;
            $display("Fail fwd_rsp.data expected %h actual %h",
                     $sampled(exp_fwd_data), $sampled(seen_fwd_data));
        end

    a_line_mask: assert property (@(posedge clk) disable iff (rst)
                                  line_wr.req |-> line_wr.mask == exp_line_mask)
        else begin
            error_count = error_count + 1;
            $display("Fail line_wr.mask expected %h actual %h",
                     $sampled(exp_line_mask), $sampled(line_wr.mask));
        end

    a_line_data: assert property (@(posedge clk) disable iff (rst)
                                  line_wr.req |-> seen_line_data == exp_line_data)
        else begin
            error_count = error_count + 1;
            $display("Fail line_wr.data expected %h actual %h",
                     $sampled(exp_line_data), $sampled(seen_line_data));
        end

    // A freed index is only sent again after it holds a new line
    a_line_owner: assert property (@(posedge clk) disable iff (rst) line_wr.req |->
                      idx_valid[line_wr.idx]
                      && line_wr.addr == line_base(idx_line[line_wr.idx]))
        else begin
            error_count = error_count + 1;
            $display("Fail line_wr.addr expected %h actual %h",
                     line_base(idx_line[$sampled(line_wr.idx)]), $sampled(line_wr.addr));
        end

    a_conflict: assert property (@(posedge clk) disable iff (rst) must_conflict |-> conflict)
        else begin
            error_count = error_count + 1;
            $display("Fail conflict expected %h actual %h", 1'b1, $sampled(conflict));
        end

    initial begin
        int wait_cycles;
        lfsr          = 32'd98478;
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        store         = '0;
        fwd           = '0;
        cache_ready   = 1'b0;
        cache_rsp     = '0;
        traffic_on    = 1'b0;
        draining      = 1'b0;
        repeat (4) @(posedge clk);
        rst        <= 1'b0;
        traffic_on <= 1'b1;
        repeat (3000) @(posedge clk);
        traffic_on <= 1'b0;
        draining   <= 1'b1;
        wait_cycles = 0;
        while ((store.en || staged.en || idx_valid != '0) && wait_cycles < 1000) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= 1000) begin
            timeout_count++;
            $display("Timeout: buffered lines were not all written to the cache");
        end
        $display("Errors: %0d data checks, %0d bound checks, %0d timeouts",
                 error_count, uut.u_sva.sva_errors, timeout_count);
        if (error_count == 0 && uut.u_sva.sva_errors == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/store_commit_sva.sv
`timescale 1ns/1ps

module store_commit_sva (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic                                                        conflict,
    input  scb_types_pkg::fwd_rsp_t                                     fwd_rsp,
    input  logic                                                        cache_ready,
    input  scb_types_pkg::line_wr_t                                     line_wr,
    input  scb_types_pkg::cache_rsp_t                                   cache_rsp,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         valid,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         writing,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0][scb_cfg_pkg::TAG_W-1:0] tags,
    input  scb_types_pkg::array_wr_t                                    wr,
    input  logic                                                        stage_en,
    input  logic [scb_cfg_pkg::TAG_W-1:0]                               stage_tag
);

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    int   sva_errors = 0;
    int   idle_cycles [SCB_ENTRIES];
    logic hit_writing;

    always_comb begin
        hit_writing = 1'b0;
        for (int i = 0; i < SCB_ENTRIES; i++) begin
            if (valid[i] && writing[i] && (tags[i] == stage_tag)) hit_writing = 1'b1;
        end
    end

    // Cycles since each entry's last write, saturating at the drain age
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SCB_ENTRIES; i++) begin
                idle_cycles[i] <= DRAIN_AGE;
            end
        end else begin
            for (int i = 0; i < SCB_ENTRIES; i++) begin
                if (wr.en && (wr.idx == SCB_IDX_W'(i))) begin
                    idle_cycles[i] <= 1;
                end else if (idle_cycles[i] < DRAIN_AGE) begin
                    idle_cycles[i] <= idle_cycles[i] + 1;
                end
            end
        end
    end

    // First cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk)
                       $fell(rst) |-> !conflict && !line_wr.req && fwd_rsp.mask == 4'h0)
        else begin
            sva_errors++;
            $error("Outputs active right after reset");
        end

    a_conflict_cause: assert property (@(posedge clk) disable iff (rst)
                          conflict |-> stage_en && (hit_writing || &valid))
        else begin
            sva_errors++;
            $error("Conflict with a free entry and no busy line");
        end

    a_req_pulse: assert property (@(posedge clk) disable iff (rst) line_wr.req |=> !line_wr.req)
        else begin
            sva_errors++;
            $error("Cache request longer than one cycle");
        end

    a_req_aged: assert property (@(posedge clk) disable iff (rst)
                    line_wr.req |-> idle_cycles[line_wr.idx] >= DRAIN_AGE)
        else begin
            sva_errors++;
            $error("Cache request too soon after a write to the entry");
        end

    a_req_cache_ready: assert property (@(posedge clk) disable iff (rst)
                           line_wr.req |-> $past(cache_ready, 2))
        else begin
            sva_errors++;
            $error("Cache request without cache_ready");
        end

    a_req_claimed: assert property (@(posedge clk) disable iff (rst)
                       line_wr.req |-> valid[line_wr.idx] && writing[line_wr.idx])
        else begin
            sva_errors++;
            $error("Cache request for an unclaimed entry");
        end

    a_rsp_claimed: assert property (@(posedge clk) disable iff (rst)
                       (cache_rsp.success || cache_rsp.retry) |-> writing[cache_rsp.idx])
        else begin
            sva_errors++;
            $error("Cache answer for an entry not in flight");
        end

endmodule

bind store_commit_top store_commit_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .conflict    (conflict),
    .fwd_rsp     (fwd_rsp),
    .cache_ready (cache_ready),
    .line_wr     (line_wr),
    .cache_rsp   (cache_rsp),
    .valid       (valid),
    .writing     (writing),
    .tags        (tags),
    .wr          (wr),
    .stage_en    (u_intake.stage_en),
    .stage_tag   (u_intake.stage_tag)
);

// File: hw/store_commit_top.sv
`timescale 1ns/1ps

module store_commit_top (
    input  logic                      clk,
    input  logic                      rst,
    input  scb_types_pkg::store_req_t store,
    output logic                      conflict,
    input  scb_types_pkg::fwd_req_t   fwd,
    output scb_types_pkg::fwd_rsp_t   fwd_rsp,
    input  logic                      cache_ready,
    output scb_types_pkg::line_wr_t   line_wr,
    input  scb_types_pkg::cache_rsp_t cache_rsp
);

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    array_wr_t                              wr;
    logic [SCB_ENTRIES-1:0]                 valid;
    logic [SCB_ENTRIES-1:0]                 writing;
    logic [SCB_ENTRIES-1:0]                 ready;
    logic [SCB_ENTRIES-1:0][TAG_W-1:0]      tags;
    logic                                   set_writing;
    logic [SCB_IDX_W-1:0]                   sel_idx;
    logic [LINE_BANKS-1:0][31:0]            line_data;
    logic [LINE_BANKS-1:0][3:0]             line_mask;

    store_intake u_intake (
        .clk      (clk),
        .rst      (rst),
        .store    (store),
        .valid    (valid),
        .writing  (writing),
        .tags     (tags),
        .conflict (conflict),
        .wr       (wr)
    );

    commit_line_array u_array (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .set_writing (set_writing),
        .sel_idx     (sel_idx),
        .rsp         (cache_rsp),
        .fwd         (fwd),
        .fwd_rsp     (fwd_rsp),
        .valid       (valid),
        .writing     (writing),
        .tags        (tags),
        .ready       (ready),
        .line_data   (line_data),
        .line_mask   (line_mask)
    );

    dcache_drain u_drain (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .tags        (tags),
        .cache_ready (cache_ready),
        .line_data   (line_data),
        .line_mask   (line_mask),
        .set_writing (set_writing),
        .sel_idx     (sel_idx),
        .line_wr     (line_wr)
    );

endmodule

// File: hw/dcache_drain.sv
`timescale 1ns/1ps

module dcache_drain (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         ready,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0][scb_cfg_pkg::TAG_W-1:0] tags,
    input  logic                                                        cache_ready,
    input  logic [scb_cfg_pkg::LINE_BANKS-1:0][31:0]                    line_data,
    input  logic [scb_cfg_pkg::LINE_BANKS-1:0][3:0]                     line_mask,
    output logic                                                        set_writing,
    output logic [scb_cfg_pkg::SCB_IDX_W-1:0]                           sel_idx,
    output scb_types_pkg::line_wr_t                                     line_wr
);

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    drain_state_e         state;
    logic [SCB_IDX_W-1:0] pick_idx;
    logic [SCB_IDX_W-1:0] sel_q;

    // Lowest ready entry
    always_comb begin
        pick_idx = '0;
        for (int i = SCB_ENTRIES - 1; i >= 0; i--) begin
            if (ready[i]) begin
                pick_idx = SCB_IDX_W'(i);
            end
        end
    end

    // --------------------------------------------------
    // Drain FSM
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DR_IDLE;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (cache_ready && |ready) begin
                        state <= DR_SELECT;
                    end
                end
                DR_SELECT: state <= DR_ISSUE;  // Array snapshots the line here
                DR_ISSUE:  state <= DR_IDLE;
                default:   state <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DR_IDLE) begin
            sel_q <= pick_idx;
        end
    end

    assign set_writing = (state == DR_SELECT);
    assign sel_idx     = sel_q;

    always_comb begin
        line_wr.req  = (state == DR_ISSUE);
        line_wr.idx  = sel_q;
        line_wr.addr = {tags[sel_q], {LINE_OFS_W{1'b0}}};
        line_wr.data = line_data;
        line_wr.mask = line_mask;
    end

endmodule

// File: hw/commit_line_array.sv
`timescale 1ns/1ps

module commit_line_array (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  scb_types_pkg::array_wr_t                                    wr,
    input  logic                                                        set_writing,
    input  logic [scb_cfg_pkg::SCB_IDX_W-1:0]                           sel_idx,
    input  scb_types_pkg::cache_rsp_t                                   rsp,
    input  scb_types_pkg::fwd_req_t                                     fwd,
    output scb_types_pkg::fwd_rsp_t                                     fwd_rsp,
    output logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         valid,
    output logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         writing,
    output logic [scb_cfg_pkg::SCB_ENTRIES-1:0][scb_cfg_pkg::TAG_W-1:0] tags,
    output logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         ready,
    output logic [scb_cfg_pkg::LINE_BANKS-1:0][31:0]                    line_data,
    output logic [scb_cfg_pkg::LINE_BANKS-1:0][3:0]                     line_mask
);

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    logic [SCB_ENTRIES-1:0]                       writing_q;
    logic [SCB_ENTRIES-1:0][DRAIN_AGE-1:0]        age;
    logic [SCB_ENTRIES-1:0][LINE_BANKS-1:0][31:0] data_q;
    logic [SCB_ENTRIES-1:0][LINE_BANKS-1:0][3:0]  mask_q;
    logic [TAG_W-1:0]                             fwd_tag;
    logic [BANK_W-1:0]                            fwd_bank;
    logic                                         fwd_hit;
    logic [SCB_IDX_W-1:0]                         fwd_idx;
    logic [3:0]                                   fwd_mask_q;
    logic [31:0]                                  fwd_data_q;

    // --------------------------------------------------
    // Entry status
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid     <= '0;
            writing_q <= '0;
        end else begin
            if (wr.en && wr.is_new) begin
                valid[wr.idx] <= 1'b1;
            end
            if (set_writing) begin
                writing_q[sel_idx] <= 1'b1;
            end
            if (rsp.success || rsp.retry) begin
                writing_q[rsp.idx] <= 1'b0;
            end
            if (rsp.success) begin
                valid[rsp.idx] <= 1'b0;
            end
        end
    end

    // The claimed entry already counts as writing in its select cycle, so no
    // store can merge into a line whose copy is being taken
    always_comb begin
        writing = writing_q;
        if (set_writing) begin
            writing[sel_idx] = 1'b1;
        end
    end

    // A write in this cycle restarts the entry's age, so it is not offered
    for (genvar i = 0; i < SCB_ENTRIES; i++) begin : g_ready
        assign ready[i] = age[i][0] & valid[i] & ~writing_q[i]
                        & ~(wr.en && (wr.idx == SCB_IDX_W'(i)));
    end

    // --------------------------------------------------
    // Tags, age counters and line storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < SCB_ENTRIES; i++) begin
            if (!age[i][0]) begin
                age[i] <= age[i] >> 1;
            end
        end
        if (wr.en) begin
            age[wr.idx] <= DRAIN_AGE'(1) << (DRAIN_AGE - 1);
            if (wr.is_new) begin
                tags[wr.idx] <= wr.tag;
            end
            for (int b = 0; b < LINE_BANKS; b++) begin
                mask_q[wr.idx][b] <= (wr.is_new ? 4'b0000 : mask_q[wr.idx][b])
                                   | ((BANK_W'(b) == wr.bank) ? wr.mask : 4'b0000);
            end
            for (int j = 0; j < 4; j++) begin
                if (wr.mask[j]) begin
                    data_q[wr.idx][wr.bank][8*j +: 8] <= wr.data[8*j +: 8];
                end
            end
        end
    end

    // Snapshot of the claimed line for the drain
    always_ff @(posedge clk) begin
        if (set_writing) begin
            line_data <= data_q[sel_idx];
            line_mask <= mask_q[sel_idx];
        end
    end

    // --------------------------------------------------
    // Store-to-load forwarding
    // --------------------------------------------------
    assign fwd_tag  = fwd.addr[ADDR_W-1:LINE_OFS_W];
    assign fwd_bank = fwd.addr[LINE_OFS_W-1:2];

    always_comb begin
        fwd_hit = 1'b0;
        fwd_idx = '0;
        for (int i = 0; i < SCB_ENTRIES; i++) begin
            if (valid[i] && (tags[i] == fwd_tag)) begin
                fwd_hit = 1'b1;
                fwd_idx = SCB_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_mask_q <= 4'b0000;
        end else begin
            fwd_mask_q <= (fwd.en && fwd_hit) ? mask_q[fwd_idx][fwd_bank] : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        fwd_data_q <= data_q[fwd_idx][fwd_bank];   // Only meaningful under the mask
    end

    assign fwd_rsp = '{mask: fwd_mask_q, data: fwd_data_q};

endmodule

// File: hw/store_intake.sv
`timescale 1ns/1ps

module store_intake (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  scb_types_pkg::store_req_t                                   store,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         valid,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0]                         writing,
    input  logic [scb_cfg_pkg::SCB_ENTRIES-1:0][scb_cfg_pkg::TAG_W-1:0] tags,
    output logic                                                        conflict,
    output scb_types_pkg::array_wr_t                                    wr
);

    import scb_cfg_pkg::*;
    import scb_types_pkg::*;

    logic                   stage_en;
    logic [ADDR_W-1:0]      stage_addr;
    logic [3:0]             stage_mask;
    logic [31:0]            stage_data;
    logic [TAG_W-1:0]       stage_tag;
    logic [SCB_ENTRIES-1:0] hit_vec;
    logic                   hit;
    logic                   hit_writing;
    logic [SCB_IDX_W-1:0]   hit_idx;
    logic [SCB_IDX_W-1:0]   free_idx;
    logic                   free_valid;
    intake_act_e            act;

    // --------------------------------------------------
    // Staging register, frozen while a conflict is raised
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_en <= 1'b0;
        end else if (!conflict) begin
            stage_en <= store.en;
        end
    end

    always_ff @(posedge clk) begin
        if (!conflict) begin
            stage_addr <= store.addr;
            stage_mask <= store.mask;
            stage_data <= store.data;
        end
    end

    assign stage_tag = stage_addr[ADDR_W-1:LINE_OFS_W];

    // Tag match and lowest free slot, scanned from the top so the lowest index wins
    always_comb begin
        hit_idx    = '0;
        free_idx   = '0;
        free_valid = 1'b0;
        for (int i = SCB_ENTRIES - 1; i >= 0; i--) begin
            hit_vec[i] = valid[i] && (tags[i] == stage_tag);
            if (hit_vec[i]) begin
                hit_idx = SCB_IDX_W'(i);
            end
            if (!valid[i]) begin
                free_idx   = SCB_IDX_W'(i);
                free_valid = 1'b1;
            end
        end
    end

    assign hit         = |hit_vec;
    assign hit_writing = |(hit_vec & writing);  // At most one entry holds a given line

    always_comb begin
        act = ACT_IDLE;
        if (stage_en) begin
            if (hit_writing) begin
                act = ACT_CONFLICT;                 // Line is on its way to the cache
            end else if (hit) begin
                act = ACT_MERGE;
            end else if (free_valid) begin
                act = ACT_ALLOC;
            end else begin
                act = ACT_CONFLICT;
            end
        end
    end

    assign conflict = (act == ACT_CONFLICT);

    always_comb begin
        wr.en     = (act == ACT_MERGE) || (act == ACT_ALLOC);
        wr.is_new = (act == ACT_ALLOC);
        wr.idx    = (act == ACT_ALLOC) ? free_idx : hit_idx;
        wr.tag    = stage_tag;
        wr.bank   = stage_addr[LINE_OFS_W-1:2];
        wr.mask   = stage_mask;
        wr.data   = stage_data;
    end

endmodule

// File: hw/scb_types_pkg.sv
package scb_types_pkg;

    import scb_cfg_pkg::*;

    // Committed store from the core
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        mask;
        logic [31:0]       data;
    } store_req_t;

    // Word write from the intake stage into one line entry
    typedef struct packed {
        logic                 en;
        logic                 is_new;    // Allocation, replaces the line mask
        logic [SCB_IDX_W-1:0] idx;
        logic [TAG_W-1:0]     tag;
        logic [BANK_W-1:0]    bank;
        logic [3:0]           mask;
        logic [31:0]          data;
    } array_wr_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } fwd_req_t;

    typedef struct packed {
        logic [3:0]  mask;
        logic [31:0] data;
    } fwd_rsp_t;

    // Full line write towards the data cache
    typedef struct packed {
        logic                             req;
        logic [SCB_IDX_W-1:0]             idx;
        logic [ADDR_W-1:0]                addr;
        logic [LINE_BANKS-1:0][31:0]      data;
        logic [LINE_BANKS-1:0][3:0]       mask;
    } line_wr_t;

    typedef struct packed {
        logic                 success;
        logic                 retry;
        logic [SCB_IDX_W-1:0] idx;
    } cache_rsp_t;

    typedef enum logic [1:0] {
        ACT_IDLE,
        ACT_MERGE,
        ACT_ALLOC,
        ACT_CONFLICT
    } intake_act_e;

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_SELECT,
        DR_ISSUE
    } drain_state_e;

endpackage

// File: hw/scb_cfg_pkg.sv
package scb_cfg_pkg;

    // --------------------------------------------------
    // Entry array
    // --------------------------------------------------
    localparam int SCB_ENTRIES = 4;
    localparam int SCB_IDX_W   = $clog2(SCB_ENTRIES);

    // --------------------------------------------------
    // Addressing and line geometry
    // --------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int LINE_BANKS = 4;                      // 32-bit words per line
    localparam int BANK_W     = $clog2(LINE_BANKS);
    localparam int LINE_OFS_W = BANK_W + 2;             // Byte offset inside a line
    localparam int TAG_W      = ADDR_W - LINE_OFS_W;

    // Idle cycles an entry waits after its last write before it may drain.
    // The age counter is a one-hot shift register of this length
    localparam int DRAIN_AGE = 3;

endpackage
